// File: flist.f
+incdir+hw
hw/dfx_seq_pkg.sv
hw/dfx_reg_pkg.sv
hw/dfx_regs.sv
hw/dfx_sequencer.sv
hw/dfx_fetch.sv
hw/wb_dfx_controller.sv
sim/dfx_asserts.sv
sim/tb_dfx_controller.sv

// File: hw/dfx_cfg.svh
// sizes and delays shared by all blocks; the delay counts must stay at 1 or more
`ifndef DFX_CFG_SVH
`define DFX_CFG_SVH

// bus widths
`define DFX_WB_ADR_W 28          // master word address, byte lanes not counted
`define DFX_REG_ADR_W 5          // slave register index
`define DFX_LEN_W 20             // bitstream length in words

// fetch pacing
`define DFX_MAX_OUTSTANDING 4    // reads in flight before stb is held off

// partition control timing, in clk cycles
`define DFX_SHUTDOWN_CYCLES 8    // decouple to first fetch request
`define DFX_RESET_CYCLES 16      // reset hold after the last config word

`endif

// File: hw/dfx_fetch.sv
// read-only master, i_start must carry a nonzero length; acks arrive in order and csib has no back-pressure
`default_nettype none
`timescale 1ns/1ps
`include "dfx_cfg.svh"

module dfx_fetch (
  input  logic                     clk,
  input  logic                     i_rst_n,
  input  logic                     i_start,
  input  logic [`DFX_LEN_W-1:0]    i_len,
  input  logic [`DFX_WB_ADR_W-1:0] i_base,
  input  logic [31:0]              i_wbm_dat,
  input  logic                     i_wbm_ack,
  input  logic                     i_wbm_stall,
  input  logic                     i_wbm_err,
  output logic [`DFX_WB_ADR_W-1:0] o_wbm_adr,
  output logic [3:0]               o_wbm_sel,
  output logic                     o_wbm_cyc,
  output logic                     o_wbm_stb,
  output logic                     o_cfg_csib,
  output logic [31:0]              o_cfg_data,
  output logic                     o_done,
  output logic                     o_err,
  output logic [`DFX_LEN_W-1:0]    o_words_done
);

  localparam int OST_W = $clog2(`DFX_MAX_OUTSTANDING + 1);

  logic [`DFX_LEN_W-1:0] len_q;
  logic [`DFX_LEN_W-1:0] issued_q;     // requests accepted by the slave
  logic [OST_W-1:0]      ost_q;        // issued but not yet answered
  logic [`DFX_LEN_W-1:0] acked_q;      // words written to config port
  logic                  issue;
  logic                  ack_ok;
  logic                  bus_err;
  logic                  last_ack;
  logic [`DFX_LEN_W-1:0] issued_nxt;
  logic [OST_W-1:0]      ost_nxt;

  // ICAP wants each byte msb-first swapped
  function automatic logic [31:0] swap_bits(input logic [31:0] w);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) begin
      for (int k = 0; k < 8; k++) begin
        r[8*b + k] = w[8*b + 7 - k];
      end
    end
    return r;
  endfunction

  assign issue    = o_wbm_stb && !i_wbm_stall;
  assign bus_err  = o_wbm_cyc && i_wbm_err;
  assign ack_ok   = o_wbm_cyc && i_wbm_ack && !i_wbm_err;   // acks after err are dropped
  assign last_ack = ack_ok && (acked_q + 1'b1 == len_q);

  assign issued_nxt = issued_q + `DFX_LEN_W'(issue);
  assign ost_nxt    = ost_q + OST_W'(issue) - OST_W'(ack_ok);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_wbm_cyc  <= 1'b0;
      o_wbm_stb  <= 1'b0;
      o_cfg_csib <= 1'b1;
      o_done     <= 1'b0;
      o_err      <= 1'b0;
      issued_q   <= '0;
      ost_q      <= '0;
      acked_q    <= '0;
    end else begin
      o_cfg_csib <= !ack_ok;   // one strobe per acked word
      o_done     <= last_ack;
      o_err      <= bus_err;
      if (i_start) begin
        o_wbm_cyc <= 1'b1;
        o_wbm_stb <= 1'b1;
        issued_q  <= '0;
        ost_q     <= '0;
        acked_q   <= '0;
      end else if (bus_err || last_ack) begin
        o_wbm_cyc <= 1'b0;     // done or abandoned
        o_wbm_stb <= 1'b0;
        ost_q     <= '0;
        acked_q   <= acked_q + `DFX_LEN_W'(ack_ok);
      end else if (o_wbm_cyc) begin
        issued_q  <= issued_nxt;
        ost_q     <= ost_nxt;
        acked_q   <= acked_q + `DFX_LEN_W'(ack_ok);
        // stall keeps stb up since ost cannot grow without an issue
        o_wbm_stb <= (issued_nxt < len_q) && (ost_nxt < OST_W'(`DFX_MAX_OUTSTANDING));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_start) begin
      len_q     <= i_len;
      o_wbm_adr <= i_base;
    end else if (issue) begin
      o_wbm_adr <= o_wbm_adr + 1'b1;   // word address
    end
    if (ack_ok) begin
      o_cfg_data <= swap_bits(i_wbm_dat);
    end
  end

  assign o_wbm_sel    = {4{o_wbm_stb}};   // full words only
  assign o_words_done = acked_q;

endmodule

`default_nettype wire

// File: hw/dfx_reg_pkg.sv
// register map and CTRL_STAT layouts; reserved bits read as zero and are ignored on write
`default_nettype none

package dfx_reg_pkg;

  // word index on the slave bus
  typedef enum logic [4:0] {
    CTRL_STAT  = 5'd0,  // command on write, status on read
    BS_ADDR    = 5'd1,  // bitstream word address
    BS_LEN     = 5'd2,  // bitstream length in words
    WORDS_DONE = 5'd3   // read only progress count
  } dfx_reg_e;

  // write view of CTRL_STAT
  typedef struct packed {
    logic [29:0] rsvd;
    logic        clear_fault;  // bit 1
    logic        trigger;      // bit 0
  } dfx_cmd_t;

  // read view of CTRL_STAT
  typedef struct packed {
    logic [22:0] rsvd_hi;
    logic        busy;         // bit 8
    logic [1:0]  rsvd_mid;
    logic [1:0]  fault;        // bits 5:4, dfx_fault_e
    logic        rsvd_lo;
    logic [2:0]  state;        // bits 2:0, dfx_state_e
  } dfx_status_t;

  // same word, decoded by direction
  typedef union packed {
    dfx_cmd_t    cmd;
    dfx_status_t status;
  } dfx_ctrl_stat_u;

endpackage

`default_nettype wire

// File: hw/dfx_regs.sv
// slave answers one cycle after the request and never stalls; BS_ADDR and BS_LEN are frozen while busy
`default_nettype none
`timescale 1ns/1ps
`include "dfx_cfg.svh"

module dfx_regs
  import dfx_reg_pkg::*;
  import dfx_seq_pkg::*;
(
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic                      i_wbs_cyc,
  input  logic                      i_wbs_stb,
  input  logic                      i_wbs_we,
  input  logic [`DFX_REG_ADR_W-1:0] i_wbs_adr,
  input  logic [31:0]               i_wbs_dat_w,
  input  logic [3:0]                i_wbs_sel,
  input  dfx_state_e                i_state,
  input  dfx_fault_e                i_fault,
  input  logic                      i_busy,
  input  logic [`DFX_LEN_W-1:0]     i_words_done,
  output logic [31:0]               o_wbs_dat_r,
  output logic                      o_wbs_ack,
  output logic                      o_wbs_err,
  output logic                      o_cmd_trigger,
  output logic                      o_cmd_clear,
  output logic [`DFX_WB_ADR_W-1:0]  o_bs_addr,
  output logic [`DFX_LEN_W-1:0]     o_bs_len
);

  logic           req;       // slave request this cycle
  logic           mapped;    // address hits a register
  logic [31:0]    rd_data;   // read mux
  logic           wr_ctrl;
  logic           wr_addr;
  logic           wr_len;
  dfx_ctrl_stat_u cmd_u;     // write word, command view
  dfx_ctrl_stat_u stat_u;    // read word, status view
  logic [31:0]    addr_merged;
  logic [31:0]    len_merged;

  // keep old bytes where sel is low
  function automatic logic [31:0] merge_sel(input logic [31:0] old_w,
                                            input logic [31:0] new_w,
                                            input logic [3:0]  sel);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = sel[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return r;
  endfunction

  assign req = i_wbs_cyc && i_wbs_stb;

  always_comb begin
    stat_u              = '0;                // reserved bits read zero
    stat_u.status.state = i_state;
    stat_u.status.fault = i_fault;
    stat_u.status.busy  = i_busy;
  end

  assign cmd_u = i_wbs_dat_w;

  always_comb begin
    mapped  = 1'b1;
    rd_data = '0;
    case (dfx_reg_e'(i_wbs_adr))
      CTRL_STAT:  rd_data = stat_u;
      BS_ADDR:    rd_data = 32'(o_bs_addr);  // zero extended
      BS_LEN:     rd_data = 32'(o_bs_len);
      WORDS_DONE: rd_data = 32'(i_words_done);
      default:    mapped  = 1'b0;            // answered with err
    endcase
  end

  assign wr_ctrl = req && i_wbs_we && (dfx_reg_e'(i_wbs_adr) == CTRL_STAT) && i_wbs_sel[0];
  assign wr_addr = req && i_wbs_we && (dfx_reg_e'(i_wbs_adr) == BS_ADDR) && !i_busy;
  assign wr_len  = req && i_wbs_we && (dfx_reg_e'(i_wbs_adr) == BS_LEN) && !i_busy;

  assign addr_merged = merge_sel(32'(o_bs_addr), i_wbs_dat_w, i_wbs_sel);
  assign len_merged  = merge_sel(32'(o_bs_len), i_wbs_dat_w, i_wbs_sel);

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      o_wbs_ack     <= 1'b0;
      o_wbs_err     <= 1'b0;
      o_cmd_trigger <= 1'b0;
      o_cmd_clear   <= 1'b0;
      o_bs_addr     <= '0;
      o_bs_len      <= '0;
    end else begin
      o_wbs_ack     <= req && mapped;   // busy-blocked writes still ack
      o_wbs_err     <= req && !mapped;
      o_cmd_trigger <= wr_ctrl && cmd_u.cmd.trigger;      // one-cycle pulse
      o_cmd_clear   <= wr_ctrl && cmd_u.cmd.clear_fault;
      if (wr_addr) begin
        o_bs_addr <= addr_merged[`DFX_WB_ADR_W-1:0];
      end
      if (wr_len) begin
        o_bs_len <= len_merged[`DFX_LEN_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      o_wbs_dat_r <= rd_data;   // status sampled in the request cycle
    end
  end

endmodule

`default_nettype wire

// File: hw/dfx_seq_pkg.sv
// sequencer encodings seen by software; changing a value changes the status register layout
`default_nettype none

package dfx_seq_pkg;

  // reconfiguration phase
  typedef enum logic [2:0] {
    IDLE     = 3'd0,  // partition running
    SHUTDOWN = 3'd1,  // decoupled, waiting out the fixed shutdown delay
    LOAD     = 3'd2,  // bitstream fetch in progress
    STARTUP  = 3'd3,  // reset hold after the last word
    FAULT    = 3'd4   // stuck until clear command
  } dfx_state_e;

  // why FAULT was entered
  typedef enum logic [1:0] {
    NONE     = 2'd0,
    BUS_ERR  = 2'd1,  // err seen on the master bus
    ZERO_LEN = 2'd2   // trigger with an empty length
  } dfx_fault_e;

endpackage

`default_nettype wire

// File: hw/dfx_sequencer.sv
// fixed shutdown delay replaces the module handshake; a zero-length trigger faults without a bus cycle
`default_nettype none
`timescale 1ns/1ps
`include "dfx_cfg.svh"

module dfx_sequencer
  import dfx_seq_pkg::*;
(
  input  logic                  clk,
  input  logic                  i_rst_n,
  input  logic                  i_cmd_trigger,
  input  logic                  i_cmd_clear,
  input  logic [`DFX_LEN_W-1:0] i_bs_len,
  input  logic                  i_fetch_done,
  input  logic                  i_fetch_err,
  output logic                  o_fetch_start,
  output logic [`DFX_LEN_W-1:0] o_fetch_len,
  output dfx_state_e            o_state,
  output dfx_fault_e            o_fault,
  output logic                  o_busy,
  output logic                  o_rm_decouple,
  output logic                  o_rm_reset,
  output logic                  o_event_error
);

  localparam int DLY_MAX = (`DFX_SHUTDOWN_CYCLES > `DFX_RESET_CYCLES) ?
                           `DFX_SHUTDOWN_CYCLES : `DFX_RESET_CYCLES;
  localparam int CNT_W   = $clog2(DLY_MAX + 1);

  dfx_state_e            state_q;
  dfx_fault_e            fault_q;
  logic [CNT_W-1:0]      dly_q;   // shared by SHUTDOWN and STARTUP
  logic [`DFX_LEN_W-1:0] len_q;   // length frozen at trigger

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      state_q       <= IDLE;
      fault_q       <= NONE;
      dly_q         <= '0;
      o_fetch_start <= 1'b0;
    end else begin
      o_fetch_start <= 1'b0;   // pulse by default
      case (state_q)
        IDLE: begin
          if (i_cmd_trigger && (i_bs_len == '0)) begin
            state_q <= FAULT;
            fault_q <= ZERO_LEN;
          end else if (i_cmd_trigger) begin
            state_q <= SHUTDOWN;
            dly_q   <= CNT_W'(`DFX_SHUTDOWN_CYCLES - 1);
          end
        end
        SHUTDOWN: begin
          dly_q <= dly_q - 1'b1;
          if (dly_q == '0) begin
            state_q       <= LOAD;
            o_fetch_start <= 1'b1;   // lands SHUTDOWN_CYCLES after decouple
          end
        end
        LOAD: begin
          if (i_fetch_err) begin     // err wins over a same-cycle done
            state_q <= FAULT;
            fault_q <= BUS_ERR;
          end else if (i_fetch_done) begin
            state_q <= STARTUP;
            dly_q   <= CNT_W'(`DFX_RESET_CYCLES - 1);
          end
        end
        STARTUP: begin
          dly_q <= dly_q - 1'b1;
          if (dly_q == '0) begin
            state_q <= IDLE;
          end
        end
        FAULT: begin
          if (i_cmd_clear) begin
            state_q <= IDLE;
            fault_q <= NONE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == IDLE) && i_cmd_trigger) begin
      len_q <= i_bs_len;
    end
  end

  assign o_fetch_len   = len_q;
  assign o_state       = state_q;
  assign o_fault       = fault_q;
  assign o_busy        = (state_q == SHUTDOWN) || (state_q == LOAD) || (state_q == STARTUP);
  assign o_rm_decouple = (state_q != IDLE);   // also held through FAULT
  assign o_rm_reset    = (state_q != IDLE);
  assign o_event_error = (state_q == FAULT);  // sticky until clear

endmodule

`default_nettype wire

// File: hw/wb_dfx_controller.sv
// one partition only; the ICAP primitive sits outside and sees write-only config traffic
`default_nettype none
`timescale 1ns/1ps
`include "dfx_cfg.svh"

module wb_dfx_controller
  import dfx_seq_pkg::*;
(
  input  logic                      clk,
  input  logic                      i_rst_n,
  input  logic                      i_wbs_cyc,
  input  logic                      i_wbs_stb,
  input  logic                      i_wbs_we,
  input  logic [`DFX_REG_ADR_W-1:0] i_wbs_adr,
  input  logic [31:0]               i_wbs_dat_w,
  input  logic [3:0]                i_wbs_sel,
  output logic [31:0]               o_wbs_dat_r,
  output logic                      o_wbs_ack,
  output logic                      o_wbs_err,
  input  logic [31:0]               i_wbm_dat,
  input  logic                      i_wbm_ack,
  input  logic                      i_wbm_stall,
  input  logic                      i_wbm_err,
  output logic [`DFX_WB_ADR_W-1:0]  o_wbm_adr,
  output logic [3:0]                o_wbm_sel,
  output logic                      o_wbm_cyc,
  output logic                      o_wbm_stb,
  output logic                      o_cfg_csib,
  output logic [31:0]               o_cfg_data,
  output logic                      o_rm_decouple,
  output logic                      o_rm_reset,
  output logic                      o_event_error
);

  logic                     cmd_trigger;   // regs to sequencer
  logic                     cmd_clear;
  logic [`DFX_LEN_W-1:0]    bs_len;
  logic [`DFX_WB_ADR_W-1:0] bs_addr;       // regs to fetch
  dfx_state_e               state;
  dfx_fault_e               fault;
  logic                     busy;
  logic                     fetch_start;
  logic [`DFX_LEN_W-1:0]    fetch_len;
  logic                     fetch_done;
  logic                     fetch_err;
  logic [`DFX_LEN_W-1:0]    words_done;

  dfx_regs u_regs (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_wbs_cyc    (i_wbs_cyc),
    .i_wbs_stb    (i_wbs_stb),
    .i_wbs_we     (i_wbs_we),
    .i_wbs_adr    (i_wbs_adr),
    .i_wbs_dat_w  (i_wbs_dat_w),
    .i_wbs_sel    (i_wbs_sel),
    .i_state      (state),
    .i_fault      (fault),
    .i_busy       (busy),
    .i_words_done (words_done),
    .o_wbs_dat_r  (o_wbs_dat_r),
    .o_wbs_ack    (o_wbs_ack),
    .o_wbs_err    (o_wbs_err),
    .o_cmd_trigger(cmd_trigger),
    .o_cmd_clear  (cmd_clear),
    .o_bs_addr    (bs_addr),
    .o_bs_len     (bs_len)
  );

  dfx_sequencer u_seq (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_cmd_trigger(cmd_trigger),
    .i_cmd_clear  (cmd_clear),
    .i_bs_len     (bs_len),
    .i_fetch_done (fetch_done),
    .i_fetch_err  (fetch_err),
    .o_fetch_start(fetch_start),
    .o_fetch_len  (fetch_len),
    .o_state      (state),
    .o_fault      (fault),
    .o_busy       (busy),
    .o_rm_decouple(o_rm_decouple),
    .o_rm_reset   (o_rm_reset),
    .o_event_error(o_event_error)
  );

  dfx_fetch u_fetch (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_start     (fetch_start),
    .i_len       (fetch_len),
    .i_base      (bs_addr),    // sampled at start, stable since regs block writes while busy
    .i_wbm_dat   (i_wbm_dat),
    .i_wbm_ack   (i_wbm_ack),
    .i_wbm_stall (i_wbm_stall),
    .i_wbm_err   (i_wbm_err),
    .o_wbm_adr   (o_wbm_adr),
    .o_wbm_sel   (o_wbm_sel),
    .o_wbm_cyc   (o_wbm_cyc),
    .o_wbm_stb   (o_wbm_stb),
    .o_cfg_csib  (o_cfg_csib),
    .o_cfg_data  (o_cfg_data),
    .o_done      (fetch_done),
    .o_err       (fetch_err),
    .o_words_done(words_done)
  );

endmodule

`default_nettype wire

// File: sim/dfx_asserts.sv
// bound into the top so fetch and sequencer signals meet in one place; fail_cnt is read at end of run
`default_nettype none
`timescale 1ns/1ps
`include "dfx_cfg.svh"

module dfx_asserts (
  input logic                                      clk,
  input logic                                      i_rst_n,
  input logic                                      i_wbm_cyc,
  input logic                                      i_wbm_stb,
  input logic [$clog2(`DFX_MAX_OUTSTANDING+1)-1:0] i_ost,
  input logic                                      i_cfg_csib,
  input logic                                      i_rm_decouple,
  input logic                                      i_rm_reset,
  input logic                                      i_event_error
);

  int fail_cnt = 0;   // assertion failures so far

  a_stb_cyc: assert property (@(posedge clk) disable iff (!i_rst_n) i_wbm_stb |-> i_wbm_cyc)
    else begin
      $error("master stb high without cyc");
      fail_cnt++;
    end

  a_ost_limit: assert property (@(posedge clk) disable iff (!i_rst_n)
                                i_ost <= `DFX_MAX_OUTSTANDING)
    else begin
      $error("outstanding reads above limit: %0d", i_ost);
      fail_cnt++;
    end

  // partition must be isolated while config words go out
  a_cfg_isolated: assert property (@(posedge clk) disable iff (!i_rst_n)
                                   !i_cfg_csib |-> (i_rm_decouple && i_rm_reset))
    else begin
      $error("config strobe while partition not decoupled and in reset");
      fail_cnt++;
    end

  a_err_decoupled: assert property (@(posedge clk) disable iff (!i_rst_n)
                                    i_event_error |-> i_rm_decouple)
    else begin
      $error("event error without decouple");
      fail_cnt++;
    end

endmodule

bind wb_dfx_controller dfx_asserts u_asserts (
  .clk          (clk),
  .i_rst_n      (i_rst_n),
  .i_wbm_cyc    (o_wbm_cyc),
  .i_wbm_stb    (o_wbm_stb),
  .i_ost        (u_fetch.ost_q),     // fetch engine in-flight count
  .i_cfg_csib   (o_cfg_csib),
  .i_rm_decouple(o_rm_decouple),
  .i_rm_reset   (o_rm_reset),
  .i_event_error(o_event_error)
);

`default_nettype wire

// File: sim/tb_dfx_controller.sv
// memory model holds 1024 words, so base plus length must stay below that; slave answers in 1 cycle
`default_nettype none
`timescale 1ns/1ps
`include "dfx_cfg.svh"

module tb_dfx_controller
  import dfx_seq_pkg::*;
  import dfx_reg_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int MEM_WORDS   = 1024;
  localparam int MAX_ACK_DLY = 3;                 // model ack delay is 0..3
  localparam int TOTAL_WORDS = 32 + 40 + 20 + 48; // words over all loads
  localparam int N_TESTS     = 5;
  localparam int FIXED_CYC   = `DFX_SHUTDOWN_CYCLES + `DFX_RESET_CYCLES + 64;
  localparam int TIMEOUT_CYC = 2 * (TOTAL_WORDS * (MAX_ACK_DLY + 2) + N_TESTS * FIXED_CYC);

  logic        clk = 1'b0;
  logic        rst_n;
  logic        i_wbs_cyc, i_wbs_stb, i_wbs_we;
  logic [4:0]  i_wbs_adr;
  logic [31:0] i_wbs_dat_w;
  logic [3:0]  i_wbs_sel;
  logic [31:0] i_wbm_dat = '0;     // driven by the memory model
  logic        i_wbm_ack = 1'b0;
  logic        i_wbm_stall = 1'b0;
  logic        i_wbm_err = 1'b0;
  logic [31:0] o_wbs_dat_r, o_cfg_data;
  logic        o_wbs_ack, o_wbs_err, o_wbm_cyc, o_wbm_stb, o_cfg_csib;
  logic        o_rm_decouple, o_rm_reset, o_event_error;
  logic [3:0]  o_wbm_sel;
  logic [`DFX_WB_ADR_W-1:0] o_wbm_adr;

  integer      seed = 32'h81f74985;
  int          err_cnt = 0;
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] cap_q [$];                       // every config strobe
  logic [`DFX_WB_ADR_W-1:0] pend_q [$];          // accepted reads, in order
  logic [`DFX_WB_ADR_W-1:0] head_adr;
  int          ack_wait = 0;
  int          served = 0;                       // responses in this load
  int          err_at = -1;                      // response index that gets err
  logic        stall_en = 1'b0;
  logic        delay_en = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  wb_dfx_controller DUT (
    .clk(clk), .i_rst_n(rst_n),
    .i_wbs_cyc(i_wbs_cyc), .i_wbs_stb(i_wbs_stb), .i_wbs_we(i_wbs_we),
    .i_wbs_adr(i_wbs_adr), .i_wbs_dat_w(i_wbs_dat_w), .i_wbs_sel(i_wbs_sel),
    .o_wbs_dat_r(o_wbs_dat_r), .o_wbs_ack(o_wbs_ack), .o_wbs_err(o_wbs_err),
    .i_wbm_dat(i_wbm_dat), .i_wbm_ack(i_wbm_ack), .i_wbm_stall(i_wbm_stall),
    .i_wbm_err(i_wbm_err), .o_wbm_adr(o_wbm_adr), .o_wbm_sel(o_wbm_sel),
    .o_wbm_cyc(o_wbm_cyc), .o_wbm_stb(o_wbm_stb), .o_cfg_csib(o_cfg_csib),
    .o_cfg_data(o_cfg_data), .o_rm_decouple(o_rm_decouple), .o_rm_reset(o_rm_reset),
    .o_event_error(o_event_error)
  );

  // memory slave: answer for the coming posedge first, then decide stall and log the request
  always @(negedge clk) begin
    i_wbm_ack = 1'b0;
    i_wbm_err = 1'b0;
    if (!o_wbm_cyc) pend_q.delete();            // abandoned reads
    if (pend_q.size() > 0) begin
      if (ack_wait > 0) begin
        ack_wait--;
      end else begin
        head_adr = pend_q.pop_front();
        if (served == err_at) begin
          i_wbm_err = 1'b1;
        end else begin
          i_wbm_ack = 1'b1;
          i_wbm_dat = mem[head_adr % MEM_WORDS];
        end
        served++;
        ack_wait = delay_en ? ($random(seed) & MAX_ACK_DLY) : 0;
      end
    end
    if (rst_n && o_wbm_stb) check_word("o_wbm_sel", 32'hF, 32'(o_wbm_sel));   // full words
    i_wbm_stall = stall_en && (($random(seed) & 1) != 0);
    if (o_wbm_stb && !i_wbm_stall) pend_q.push_back(o_wbm_adr);
  end

  always @(negedge clk) begin
    if (rst_n && !o_cfg_csib) cap_q.push_back(o_cfg_data);   // csib stable mid-cycle
  end

  // bit k of each byte moves to 7-k, i.e. bit index xor 7
  function automatic logic [31:0] reverse_in_bytes(input logic [31:0] w);
    logic [31:0] r;
    for (int i = 0; i < 32; i++) r[i] = w[i ^ 7];
    return r;
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("Fail %0t %s expected %h got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_state(input string name, input dfx_state_e exp, input dfx_state_e act);
    if (exp !== act) begin
      err_cnt++;
      $display("Fail %0t %s expected %s got %s", $time, name, exp.name(), act.name());
    end
  endtask

  task automatic check_fault(input string name, input dfx_fault_e exp, input dfx_fault_e act);
    if (exp !== act) begin
      err_cnt++;
      $display("Fail %0t %s expected %s got %s", $time, name, exp.name(), act.name());
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      err_cnt++;
      $display("Fail %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_response(input logic [4:0] adr, input logic exp_err);
    if (exp_err && (!o_wbs_err || o_wbs_ack)) begin
      err_cnt++;
      $display("no err response at %0t for unmapped address %0d", $time, adr);
    end else if (!exp_err && (!o_wbs_ack || o_wbs_err)) begin
      err_cnt++;
      $display("no ack at %0t for register %0d", $time, adr);
    end
  endtask

  task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat, input logic [3:0] sel,
                          input logic exp_err);
    @(negedge clk);
    i_wbs_cyc = 1'b1;
    i_wbs_stb = 1'b1;
    i_wbs_we = 1'b1;
    i_wbs_adr = adr;
    i_wbs_dat_w = dat;
    i_wbs_sel = sel;
    @(negedge clk);                              // response registered one cycle later
    i_wbs_cyc = 1'b0;
    i_wbs_stb = 1'b0;
    i_wbs_we = 1'b0;
    check_response(adr, exp_err);
  endtask

  task automatic wb_read(input logic [4:0] adr, output logic [31:0] dat, input logic exp_err);
    @(negedge clk);
    i_wbs_cyc = 1'b1;
    i_wbs_stb = 1'b1;
    i_wbs_we = 1'b0;
    i_wbs_adr = adr;
    @(negedge clk);
    i_wbs_cyc = 1'b0;
    i_wbs_stb = 1'b0;
    dat = o_wbs_dat_r;
    check_response(adr, exp_err);
  endtask

  task automatic read_status(output dfx_state_e st, output dfx_fault_e ft, output logic busy);
    dfx_ctrl_stat_u u;
    logic [31:0] rd;
    wb_read(CTRL_STAT, rd, 1'b0);
    u = rd;                                      // status view of the word
    st = dfx_state_e'(u.status.state);
    ft = dfx_fault_e'(u.status.fault);
    busy = u.status.busy;
  endtask

  // only called for IDLE and FAULT, neither of which is busy
  task automatic expect_status(input dfx_state_e st_exp, input dfx_fault_e ft_exp);
    dfx_state_e st;
    dfx_fault_e ft;
    logic busy;
    read_status(st, ft, busy);
    check_state("status.state", st_exp, st);
    check_fault("status.fault", ft_exp, ft);
    check_bit("status.busy", 1'b0, busy);
  endtask

  task automatic check_capture(input int base, input int n);
    check_word("captured word count", n, cap_q.size());
    for (int i = 0; i < n && i < cap_q.size(); i++) begin
      check_word($sformatf("o_cfg_data[%0d]", i), reverse_in_bytes(mem[(base + i) % MEM_WORDS]),
                 cap_q[i]);
    end
  endtask

  task automatic start_load(input int base, input int len);
    cap_q.delete();
    served = 0;
    wb_write(BS_ADDR, base, 4'hF, 1'b0);
    wb_write(BS_LEN, len, 4'hF, 1'b0);
    wb_write(CTRL_STAT, 32'h1, 4'hF, 1'b0);      // trigger
    check_bit("o_rm_decouple", 1'b0, o_rm_decouple);   // command pulse cycle
    @(negedge clk);
    check_bit("o_rm_decouple", 1'b1, o_rm_decouple);
    check_bit("o_rm_reset", 1'b1, o_rm_reset);
  endtask

  task automatic finish_load(input int base, input int len);
    int hold;
    logic [31:0] rd;
    hold = 0;
    while (o_rm_decouple) begin
      @(negedge clk);
      if (o_rm_decouple) check_bit("o_rm_reset", 1'b1, o_rm_reset);   // move together
      else check_bit("o_rm_reset", 1'b0, o_rm_reset);
      if (!o_cfg_csib) hold = 0;
      else if (o_rm_decouple) hold++;
    end
    if (hold != `DFX_RESET_CYCLES) begin
      err_cnt++;
      $display("partition released %0d cycles after the last config word, expected %0d",
               hold, `DFX_RESET_CYCLES);
    end
    check_capture(base, len);
    wb_read(WORDS_DONE, rd, 1'b0);
    check_word("WORDS_DONE", len, rd);
    expect_status(IDLE, NONE);
  endtask

  task automatic clear_fault();
    wb_write(CTRL_STAT, 32'h2, 4'hF, 1'b0);
    @(negedge clk);                              // state register follows the pulse
    check_bit("o_rm_decouple", 1'b0, o_rm_decouple);
    check_bit("o_rm_reset", 1'b0, o_rm_reset);
    check_bit("o_event_error", 1'b0, o_event_error);
    expect_status(IDLE, NONE);
  endtask

  task automatic test_reg_map();
    logic [31:0] rd;
    check_bit("o_wbm_cyc", 1'b0, o_wbm_cyc);
    check_bit("o_cfg_csib", 1'b1, o_cfg_csib);
    check_bit("o_event_error", 1'b0, o_event_error);
    expect_status(IDLE, NONE);
    wb_write(BS_ADDR, 32'h0000_0123, 4'hF, 1'b0);
    wb_write(BS_ADDR, 32'hAABB_CCDD, 4'b0010, 1'b0);   // byte 1 only
    wb_read(BS_ADDR, rd, 1'b0);
    check_word("BS_ADDR", 32'h0000_CC23, rd);
    wb_write(BS_LEN, 32'h0000_0240, 4'hF, 1'b0);
    wb_write(BS_LEN, 32'h0000_5511, 4'b0001, 1'b0);
    wb_read(BS_LEN, rd, 1'b0);
    check_word("BS_LEN", 32'h0000_0211, rd);
    wb_read(5'd9, rd, 1'b1);
    wb_write(5'd12, 32'h1, 4'hF, 1'b1);
  endtask

  task automatic test_bus_error();
    err_at = 5;
    start_load(400, 20);
    while (!o_event_error) @(negedge clk);
    check_bit("o_rm_decouple", 1'b1, o_rm_decouple);
    check_bit("o_rm_reset", 1'b1, o_rm_reset);
    expect_status(FAULT, BUS_ERR);
    check_capture(400, 5);                       // in-order words before the err
    err_at = -1;
    clear_fault();
  endtask

  task automatic test_triggers();
    logic [31:0] rd;
    stall_en = 1'b1;
    delay_en = 1'b1;
    start_load(600, 48);
    while (!o_wbm_cyc) @(negedge clk);
    wb_write(BS_LEN, 32'd7, 4'hF, 1'b0);         // acked, ignored while busy
    wb_write(CTRL_STAT, 32'h1, 4'hF, 1'b0);      // no restart
    wb_read(BS_LEN, rd, 1'b0);
    check_word("BS_LEN", 32'd48, rd);
    finish_load(600, 48);
    wb_write(BS_LEN, 32'd0, 4'hF, 1'b0);
    wb_write(CTRL_STAT, 32'h1, 4'hF, 1'b0);
    repeat (4) begin
      @(negedge clk);
      check_bit("o_wbm_cyc", 1'b0, o_wbm_cyc);
    end
    check_bit("o_event_error", 1'b1, o_event_error);
    expect_status(FAULT, ZERO_LEN);
    clear_fault();
  endtask

  initial begin
    rst_n = 1'b0;
    i_wbs_cyc = 1'b0;
    i_wbs_stb = 1'b0;
    i_wbs_we = 1'b0;
    i_wbs_adr = '0;
    i_wbs_dat_w = '0;
    i_wbs_sel = '0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = $random(seed);
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    test_reg_map();
    start_load(16, 32);                          // plain load
    finish_load(16, 32);
    stall_en = 1'b1;
    delay_en = 1'b1;
    start_load(200, 40);
    finish_load(200, 40);
    stall_en = 1'b0;
    delay_en = 1'b0;
    test_bus_error();
    test_triggers();
    $display("summary: %0d check errors, %0d assertion failures", err_cnt,
             DUT.u_asserts.fail_cnt);
    if (err_cnt == 0 && DUT.u_asserts.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire
